//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_simd_alu
FILELIST   := simd_alu.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- simd_alu.f
+incdir+.
simd_lane_pkg.sv
simd_op_pkg.sv
simd_ctrl_if.sv
simd_op_decoder.sv
simd_lane_adder.sv
simd_sat_round.sv
simd_compare.sv
simd_lead_count.sv
simd_alu_top.sv
tb_simd_alu.sv

//--- simd_alu_top.sv
//////////////////////////////////////////////////
// Packed-SIMD ALU top level
// Decoder, lane units, result select and
// the single output register stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

module simd_alu_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  simd_op_pkg::simd_op_e      op_i,
  input  simd_lane_pkg::lane_width_e width_i,
  input  simd_lane_pkg::data_t       op_a_i,
  input  simd_lane_pkg::data_t       op_b_i,
  output simd_lane_pkg::data_t       result_o,
  output logic                       ovf_o,
  output logic                       valid_o
);

  simd_lane_pkg::data_t       sum, sat, half, mask, minmax, count, result_d;
  simd_lane_pkg::lane_ext_t   sum_ext;
  simd_lane_pkg::lane_flags_t lane_ovf;
  logic                       ovf_d;

  simd_ctrl_if u_ctrl ();

  simd_op_decoder u_decoder (
    .op_i    (op_i),
    .width_i (width_i),
    .ctrl    (u_ctrl.decoder)
  );

  simd_lane_adder u_adder (
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .ctrl      (u_ctrl.unit),
    .sum_o     (sum),
    .sum_ext_o (sum_ext)
  );

  simd_sat_round u_sat_round (
    .sum_i      (sum),
    .sum_ext_i  (sum_ext),
    .ctrl       (u_ctrl.unit),
    .sat_o      (sat),
    .half_o     (half),
    .lane_ovf_o (lane_ovf)
  );

  simd_compare u_compare (
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .sum_i     (sum),
    .sum_ext_i (sum_ext),
    .ctrl      (u_ctrl.unit),
    .mask_o    (mask),
    .minmax_o  (minmax)
  );

  simd_lead_count u_lead_count (
    .op_a_i  (op_a_i),
    .ctrl    (u_ctrl.unit),
    .count_o (count)
  );

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////
  always_comb begin
    case (u_ctrl.res_sel)
      simd_op_pkg::rs_sat:    result_d = sat;
      simd_op_pkg::rs_half:   result_d = half;
      simd_op_pkg::rs_cmp:    result_d = mask;
      simd_op_pkg::rs_minmax: result_d = minmax;
      simd_op_pkg::rs_count:  result_d = count;
      default:                result_d = sum;
    endcase
  end

  // Overflow only reported by saturating ops
  assign ovf_d = (u_ctrl.res_sel == simd_op_pkg::rs_sat) && (|lane_ovf);

  // Output register, loads on every strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      ovf_o    <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        ovf_o    <= ovf_d;
        result_o <= result_d;
      end
    end
  end

endmodule

//--- simd_compare.sv
//////////////////////////////////////////////////
// Lane compare and min/max
// Masks from the a - b difference, min/max pick
//////////////////////////////////////////////////

`timescale 1ns/1ps

module simd_compare (
  input  simd_lane_pkg::data_t     op_a_i,
  input  simd_lane_pkg::data_t     op_b_i,
  input  simd_lane_pkg::data_t     sum_i,
  input  simd_lane_pkg::lane_ext_t sum_ext_i,
  simd_ctrl_if.unit                ctrl,
  output simd_lane_pkg::data_t     mask_o,
  output simd_lane_pkg::data_t     minmax_o
);

  simd_lane_pkg::lane_flags_t byte_zero;
  simd_lane_pkg::lane_flags_t is_eq;
  simd_lane_pkg::lane_flags_t is_lt;
  simd_lane_pkg::lane_flags_t hit;

  always_comb begin
    for (int i = 0; i < simd_lane_pkg::lane_count; i++) begin
      byte_zero[i] = (sum_i[simd_lane_pkg::byte_width*i +: simd_lane_pkg::byte_width] == '0);
    end
  end

  // Spread lane results to every byte of the lane
  always_comb begin
    case (ctrl.lane_width)
      simd_lane_pkg::w8: begin
        is_eq = byte_zero;
        is_lt = sum_ext_i;
      end
      simd_lane_pkg::w16: begin
        is_eq = {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
        is_lt = {{2{sum_ext_i[3]}}, {2{sum_ext_i[1]}}};
      end
      default: begin
        is_eq = {simd_lane_pkg::lane_count{&byte_zero}};
        is_lt = {simd_lane_pkg::lane_count{sum_ext_i[3]}};
      end
    endcase
  end

  always_comb begin
    case (ctrl.cmp_kind)
      simd_op_pkg::ck_lt: hit = is_lt;
      simd_op_pkg::ck_le: hit = is_lt | is_eq;
      simd_op_pkg::ck_ge: hit = ~is_lt;
      default:            hit = is_eq;
    endcase
  end

  always_comb begin
    for (int i = 0; i < simd_lane_pkg::lane_count; i++) begin
      mask_o[8*i +: 8]   = {8{hit[i]}};
      minmax_o[8*i +: 8] = hit[i] ? op_a_i[8*i +: 8] : op_b_i[8*i +: 8];
    end
  end

endmodule

//--- simd_ctrl_if.sv
//////////////////////////////////////////////////
// Decoded datapath control
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface simd_ctrl_if;

  simd_lane_pkg::lane_width_e lane_width;
  logic                       signed_ops;
  logic                       subtract;
  simd_op_pkg::res_sel_e      res_sel;
  simd_op_pkg::cmp_kind_e     cmp_kind;
  // Redundant-sign count instead of zero count
  logic                       count_sign;

  modport decoder (
    output lane_width, signed_ops, subtract, res_sel, cmp_kind, count_sign
  );

  modport unit (
    input lane_width, signed_ops, subtract, res_sel, cmp_kind, count_sign
  );

endinterface

//--- simd_lane_adder.sv
//////////////////////////////////////////////////
// Lane-split adder
// Byte-sliced add/sub, carries stop at lane tops,
// ninth bit of each top slice is exact sign/carry
//////////////////////////////////////////////////

`timescale 1ns/1ps

module simd_lane_adder (
  input  simd_lane_pkg::data_t     op_a_i,
  input  simd_lane_pkg::data_t     op_b_i,
  simd_ctrl_if.unit                ctrl,
  output simd_lane_pkg::data_t     sum_o,
  output simd_lane_pkg::lane_ext_t sum_ext_o
);

  simd_lane_pkg::lane_flags_t        top;
  simd_lane_pkg::data_t              b_in;
  logic [simd_lane_pkg::byte_width:0] slice [simd_lane_pkg::lane_count];

  assign top = simd_lane_pkg::lane_top_mask(ctrl.lane_width);

  // Subtract runs as a + ~b + 1
  assign b_in = op_b_i ^ {simd_lane_pkg::data_width{ctrl.subtract}};

  //////////////////////////////////////////////////
  // Slice chain
  //////////////////////////////////////////////////
  always_comb begin
    logic a_ext;
    logic b_ext;
    logic cin;

    // Low slice of the lowest lane always takes the subtract carry
    cin = ctrl.subtract;

    for (int i = 0; i < simd_lane_pkg::lane_count; i++) begin
      // Only the top slice of a lane is extended
      a_ext = top[i] & ctrl.signed_ops &
              op_a_i[simd_lane_pkg::byte_width*i + simd_lane_pkg::byte_width-1];

      // Unsigned subtract extends ~b with a one so the ninth bit is a borrow sign
      b_ext = top[i] & (ctrl.signed_ops ?
              b_in[simd_lane_pkg::byte_width*i + simd_lane_pkg::byte_width-1] :
              ctrl.subtract);

      slice[i] = {a_ext, op_a_i[simd_lane_pkg::byte_width*i +: simd_lane_pkg::byte_width]}
               + {b_ext, b_in[simd_lane_pkg::byte_width*i +: simd_lane_pkg::byte_width]}
               + {{simd_lane_pkg::byte_width{1'b0}}, cin};

      // Next slice starts a new lane or continues this one
      cin = top[i] ? ctrl.subtract : slice[i][simd_lane_pkg::byte_width];

      sum_o[simd_lane_pkg::byte_width*i +: simd_lane_pkg::byte_width] =
        slice[i][simd_lane_pkg::byte_width-1:0];
      sum_ext_o[i] = slice[i][simd_lane_pkg::byte_width];
    end
  end

endmodule

//--- simd_lane_pkg.sv
//////////////////////////////////////////////////
// SIMD lane geometry
// Operand width, lane width selector, lane types
// and the saturation bounds for each lane width
//////////////////////////////////////////////////

package simd_lane_pkg;

  localparam int data_width = 32;
  localparam int lane_count = 4;
  localparam int byte_width = 8;

  typedef enum logic [1:0] {
    w8  = 2'd0,
    w16 = 2'd1,
    w32 = 2'd2
  } lane_width_e;

  typedef logic [data_width-1:0] data_t;
  typedef logic [lane_count-1:0] lane_flags_t;
  typedef logic [lane_count-1:0] lane_ext_t;

  // Saturation bounds
  localparam logic [7:0]  sat_u8_max  = 8'hff;
  localparam logic [7:0]  sat_s8_min  = 8'h80;
  localparam logic [7:0]  sat_s8_max  = 8'h7f;
  localparam logic [15:0] sat_s16_min = 16'h8000;
  localparam logic [15:0] sat_s16_max = 16'h7fff;
  localparam logic [31:0] sat_s32_min = 32'h8000_0000;
  localparam logic [31:0] sat_s32_max = 32'h7fff_ffff;

  // One bit per byte, set where the byte is the top byte of its lane
  function automatic lane_flags_t lane_top_mask(lane_width_e width);
    lane_flags_t mask;
    case (width)
      w8:      mask = 4'b1111;
      w16:     mask = 4'b1010;
      default: mask = 4'b1000;
    endcase
    return mask;
  endfunction

endpackage

//--- simd_lead_count.sv
//////////////////////////////////////////////////
// Leading zero and leading sign count per lane
//////////////////////////////////////////////////

`timescale 1ns/1ps

module simd_lead_count (
  input  simd_lane_pkg::data_t op_a_i,
  simd_ctrl_if.unit            ctrl,
  output simd_lane_pkg::data_t count_o
);

  simd_lane_pkg::lane_flags_t          top;
  simd_lane_pkg::lane_flags_t          flip;
  logic [simd_lane_pkg::data_width:0]   run;
  simd_lane_pkg::data_t                cnt_bits;
  logic [1:0]                          l1 [16];
  logic [2:0]                          l2 [8];
  logic [3:0]                          l3 [4];
  logic [4:0]                          l4 [2];
  logic [5:0]                          l5;

  assign top = simd_lane_pkg::lane_top_mask(ctrl.lane_width);

  // Sign count looks for a run of copies of the lane sign
  always_comb begin
    logic own_sign;

    own_sign = 1'b0;
    for (int i = simd_lane_pkg::lane_count-1; i >= 0; i--) begin
      if (top[i]) own_sign = op_a_i[simd_lane_pkg::byte_width*i + simd_lane_pkg::byte_width-1];
      flip[i] = ctrl.count_sign & own_sign;
    end
  end

  // Prefix run restarts at each lane top, sign bit itself not counted
  always_comb begin
    logic lane_msb;

    run[simd_lane_pkg::data_width] = 1'b1;
    for (int i = simd_lane_pkg::data_width-1; i >= 0; i--) begin
      lane_msb = (i % simd_lane_pkg::byte_width == simd_lane_pkg::byte_width-1) &&
                 top[i / simd_lane_pkg::byte_width];
      run[i] = ~(op_a_i[i] ^ flip[i / simd_lane_pkg::byte_width]) & (lane_msb | run[i+1]);
      cnt_bits[i] = run[i] & ~(ctrl.count_sign & lane_msb);
    end
  end

  //////////////////////////////////////////////////
  // Adder tree
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 16; i++) l1[i] = {1'b0, cnt_bits[2*i]} + {1'b0, cnt_bits[2*i+1]};
    for (int i = 0; i < 8; i++) l2[i] = {1'b0, l1[2*i]} + {1'b0, l1[2*i+1]};
    // Byte counts
    for (int i = 0; i < 4; i++) l3[i] = {1'b0, l2[2*i]} + {1'b0, l2[2*i+1]};
    // Halfword counts
    for (int i = 0; i < 2; i++) l4[i] = {1'b0, l3[2*i]} + {1'b0, l3[2*i+1]};
    l5 = {1'b0, l4[0]} + {1'b0, l4[1]};
  end

  always_comb begin
    case (ctrl.lane_width)
      simd_lane_pkg::w8:  count_o = {4'h0, l3[3], 4'h0, l3[2], 4'h0, l3[1], 4'h0, l3[0]};
      simd_lane_pkg::w16: count_o = {11'h0, l4[1], 11'h0, l4[0]};
      default:            count_o = {26'h0, l5};
    endcase
  end

endmodule

//--- simd_op_decoder.sv
//////////////////////////////////////////////////
// SIMD operation decoder
// Maps the operation code to datapath control
//////////////////////////////////////////////////

`timescale 1ns/1ps

module simd_op_decoder (
  input  simd_op_pkg::simd_op_e      op_i,
  input  simd_lane_pkg::lane_width_e width_i,
  simd_ctrl_if.decoder               ctrl
);

  assign ctrl.lane_width = width_i;

  always_comb begin
    ctrl.signed_ops = 1'b0;
    ctrl.subtract   = 1'b0;
    ctrl.res_sel    = simd_op_pkg::rs_sum;
    ctrl.cmp_kind   = simd_op_pkg::ck_eq;
    ctrl.count_sign = 1'b0;

    case (op_i)
      simd_op_pkg::op_add: ctrl.res_sel = simd_op_pkg::rs_sum;
      simd_op_pkg::op_sub: ctrl.subtract = 1'b1;

      simd_op_pkg::op_kadd, simd_op_pkg::op_ksub,
      simd_op_pkg::op_ukadd, simd_op_pkg::op_uksub: begin
        ctrl.res_sel    = simd_op_pkg::rs_sat;
        ctrl.signed_ops = (op_i == simd_op_pkg::op_kadd) || (op_i == simd_op_pkg::op_ksub);
        ctrl.subtract   = (op_i == simd_op_pkg::op_ksub) || (op_i == simd_op_pkg::op_uksub);
      end

      simd_op_pkg::op_radd, simd_op_pkg::op_rsub,
      simd_op_pkg::op_uradd, simd_op_pkg::op_ursub: begin
        ctrl.res_sel    = simd_op_pkg::rs_half;
        ctrl.signed_ops = (op_i == simd_op_pkg::op_radd) || (op_i == simd_op_pkg::op_rsub);
        ctrl.subtract   = (op_i == simd_op_pkg::op_rsub) || (op_i == simd_op_pkg::op_ursub);
      end

      // Compares and min/max all look at a - b
      simd_op_pkg::op_cmpeq: begin
        ctrl.res_sel  = simd_op_pkg::rs_cmp;
        ctrl.subtract = 1'b1;
      end

      simd_op_pkg::op_scmplt, simd_op_pkg::op_scmple,
      simd_op_pkg::op_ucmplt, simd_op_pkg::op_ucmple: begin
        ctrl.res_sel    = simd_op_pkg::rs_cmp;
        ctrl.subtract   = 1'b1;
        ctrl.signed_ops = (op_i == simd_op_pkg::op_scmplt) || (op_i == simd_op_pkg::op_scmple);
        ctrl.cmp_kind   = ((op_i == simd_op_pkg::op_scmplt) || (op_i == simd_op_pkg::op_ucmplt)) ?
                          simd_op_pkg::ck_lt : simd_op_pkg::ck_le;
      end

      simd_op_pkg::op_smin, simd_op_pkg::op_smax,
      simd_op_pkg::op_umin, simd_op_pkg::op_umax: begin
        ctrl.res_sel    = simd_op_pkg::rs_minmax;
        ctrl.subtract   = 1'b1;
        ctrl.signed_ops = (op_i == simd_op_pkg::op_smin) || (op_i == simd_op_pkg::op_smax);
        // a is kept where a < b for min, where a >= b for max
        ctrl.cmp_kind   = ((op_i == simd_op_pkg::op_smin) || (op_i == simd_op_pkg::op_umin)) ?
                          simd_op_pkg::ck_lt : simd_op_pkg::ck_ge;
      end

      simd_op_pkg::op_clz: ctrl.res_sel = simd_op_pkg::rs_count;

      simd_op_pkg::op_clrs: begin
        ctrl.res_sel    = simd_op_pkg::rs_count;
        ctrl.count_sign = 1'b1;
      end

      default: ctrl.res_sel = simd_op_pkg::rs_sum;
    endcase
  end

endmodule

//--- simd_op_pkg.sv
//////////////////////////////////////////////////
// SIMD operation encoding
// Operation codes, result sources, compare kinds
//////////////////////////////////////////////////

package simd_op_pkg;

  typedef enum logic [4:0] {
    // Wrapping
    op_add,
    op_sub,
    // Saturating
    op_kadd,
    op_ksub,
    op_ukadd,
    op_uksub,
    // Halving
    op_radd,
    op_rsub,
    op_uradd,
    op_ursub,
    // Lane compares
    op_cmpeq,
    op_scmplt,
    op_scmple,
    op_ucmplt,
    op_ucmple,
    // Min and max
    op_smin,
    op_smax,
    op_umin,
    op_umax,
    // Bit counts
    op_clz,
    op_clrs
  } simd_op_e;

  typedef enum logic [2:0] {
    rs_sum,
    rs_sat,
    rs_half,
    rs_cmp,
    rs_minmax,
    rs_count
  } res_sel_e;

  typedef enum logic [1:0] {
    ck_eq,
    ck_lt,
    ck_le,
    ck_ge
  } cmp_kind_e;

endpackage

//--- simd_sat_round.sv
//////////////////////////////////////////////////
// Saturating and halving results
// Clamps overflowing lanes, halves exact results
//////////////////////////////////////////////////

`timescale 1ns/1ps

module simd_sat_round (
  input  simd_lane_pkg::data_t       sum_i,
  input  simd_lane_pkg::lane_ext_t   sum_ext_i,
  simd_ctrl_if.unit                  ctrl,
  output simd_lane_pkg::data_t       sat_o,
  output simd_lane_pkg::data_t       half_o,
  output simd_lane_pkg::lane_flags_t lane_ovf_o
);

  simd_lane_pkg::lane_flags_t top;
  simd_lane_pkg::lane_flags_t byte_ovf;
  simd_lane_pkg::data_t       s_bound;
  logic [7:0]                 u_bound;

  assign top = simd_lane_pkg::lane_top_mask(ctrl.lane_width);

  // Carry clamps to all ones, borrow clamps to zero
  assign u_bound = ctrl.subtract ? 8'h00 : simd_lane_pkg::sat_u8_max;

  //////////////////////////////////////////////////
  // Overflow detection
  //////////////////////////////////////////////////
  always_comb begin
    logic own_ovf;

    own_ovf = 1'b0;
    // Walk down from the top byte so each byte inherits its lane's flag
    for (int i = simd_lane_pkg::lane_count-1; i >= 0; i--) begin
      if (top[i]) begin
        own_ovf = ctrl.signed_ops ?
                  (sum_ext_i[i] ^ sum_i[simd_lane_pkg::byte_width*i + simd_lane_pkg::byte_width-1]) :
                  sum_ext_i[i];
      end
      byte_ovf[i] = own_ovf;
    end
  end

  assign lane_ovf_o = byte_ovf & top;

  // Signed clamp value, side picked by the exact sign
  always_comb begin
    case (ctrl.lane_width)
      simd_lane_pkg::w8: begin
        for (int i = 0; i < simd_lane_pkg::lane_count; i++) begin
          s_bound[8*i +: 8] = sum_ext_i[i] ? simd_lane_pkg::sat_s8_min : simd_lane_pkg::sat_s8_max;
        end
      end
      simd_lane_pkg::w16: begin
        for (int h = 0; h < 2; h++) begin
          s_bound[16*h +: 16] = sum_ext_i[2*h+1] ? simd_lane_pkg::sat_s16_min :
                                                   simd_lane_pkg::sat_s16_max;
        end
      end
      default: s_bound = sum_ext_i[3] ? simd_lane_pkg::sat_s32_min : simd_lane_pkg::sat_s32_max;
    endcase
  end

  always_comb begin
    for (int i = 0; i < simd_lane_pkg::lane_count; i++) begin
      if (byte_ovf[i]) begin
        sat_o[8*i +: 8] = ctrl.signed_ops ? s_bound[8*i +: 8] : u_bound;
      end else begin
        sat_o[8*i +: 8] = sum_i[8*i +: 8];
      end
    end
  end

  //////////////////////////////////////////////////
  // Halving
  //////////////////////////////////////////////////
  always_comb begin
    half_o = {sum_ext_i[simd_lane_pkg::lane_count-1], sum_i[simd_lane_pkg::data_width-1:1]};
    // Lane tops take their own ninth bit instead of the neighbour's low bit
    for (int i = 0; i < simd_lane_pkg::lane_count-1; i++) begin
      if (top[i]) half_o[simd_lane_pkg::byte_width*i + simd_lane_pkg::byte_width-1] = sum_ext_i[i];
    end
  end

endmodule

//--- tb_simd_model.svh
//////////////////////////////////////////////////
// Reference model for the packed-SIMD ALU
// Lane-by-lane arithmetic plus the stimulus LCG
//////////////////////////////////////////////////

`ifndef TB_SIMD_MODEL_SVH
`define TB_SIMD_MODEL_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Count of leading lane bits equal to v from the lane top down
function automatic int lead_run(input longint lane, input int lw, input bit v);
  int n;
  bit stop;
  n = 0;
  stop = 1'b0;
  for (int i = lw - 1; i >= 0; i--) begin
    if (!stop && (lane[i] == v)) n++;
    else stop = 1'b1;
  end
  return n;
endfunction

function automatic longint signed_lane_max(input int lw);
  if (lw == 8) return longint'($signed(simd_lane_pkg::sat_s8_max));
  if (lw == 16) return longint'($signed(simd_lane_pkg::sat_s16_max));
  return longint'($signed(simd_lane_pkg::sat_s32_max));
endfunction

function automatic longint signed_lane_min(input int lw);
  if (lw == 8) return longint'($signed(simd_lane_pkg::sat_s8_min));
  if (lw == 16) return longint'($signed(simd_lane_pkg::sat_s16_min));
  return longint'($signed(simd_lane_pkg::sat_s32_min));
endfunction

// Returns {overflow, result}
function automatic logic [32:0] model_alu(
  input simd_op_pkg::simd_op_e      op,
  input simd_lane_pkg::lane_width_e width,
  input logic [31:0]                a,
  input logic [31:0]                b
);
  int     lw;
  longint m;
  longint half_range;
  longint ua;
  longint ub;
  longint x;
  longint y;
  longint r;
  longint res;
  logic   ovf;
  logic   sgn;
  lw = (width == simd_lane_pkg::w8) ? 8 : ((width == simd_lane_pkg::w16) ? 16 : 32);
  m = (longint'(1) << lw) - 1;
  half_range = longint'(1) << (lw - 1);
  res = 0;
  ovf = 1'b0;
  sgn = op inside {simd_op_pkg::op_kadd, simd_op_pkg::op_ksub, simd_op_pkg::op_radd,
                   simd_op_pkg::op_rsub, simd_op_pkg::op_scmplt, simd_op_pkg::op_scmple,
                   simd_op_pkg::op_smin, simd_op_pkg::op_smax};
  for (int l = 0; l < 32 / lw; l++) begin
    ua = (longint'(a) >> (l * lw)) & m;
    ub = (longint'(b) >> (l * lw)) & m;
    // Signed view of the lane when the op is signed
    x = (sgn && ua >= half_range) ? ua - (m + 1) : ua;
    y = (sgn && ub >= half_range) ? ub - (m + 1) : ub;
    case (op)
      simd_op_pkg::op_add, simd_op_pkg::op_kadd, simd_op_pkg::op_ukadd,
      simd_op_pkg::op_radd, simd_op_pkg::op_uradd: r = x + y;
      simd_op_pkg::op_sub, simd_op_pkg::op_ksub, simd_op_pkg::op_uksub,
      simd_op_pkg::op_rsub, simd_op_pkg::op_ursub: r = x - y;
      simd_op_pkg::op_cmpeq: r = (x == y) ? m : 0;
      simd_op_pkg::op_scmplt, simd_op_pkg::op_ucmplt: r = (x < y) ? m : 0;
      simd_op_pkg::op_scmple, simd_op_pkg::op_ucmple: r = (x <= y) ? m : 0;
      simd_op_pkg::op_smin, simd_op_pkg::op_umin: r = (x < y) ? x : y;
      simd_op_pkg::op_smax, simd_op_pkg::op_umax: r = (x > y) ? x : y;
      simd_op_pkg::op_clz: r = longint'(lead_run(ua, lw, 1'b0));
      // Sign bit itself is not redundant
      default: r = longint'(lead_run(ua, lw, ua[lw-1])) - 1;
    endcase
    if (op inside {simd_op_pkg::op_kadd, simd_op_pkg::op_ksub}) begin
      if (r > signed_lane_max(lw)) begin
        r = signed_lane_max(lw);
        ovf = 1'b1;
      end else if (r < signed_lane_min(lw)) begin
        r = signed_lane_min(lw);
        ovf = 1'b1;
      end
    end
    if (op inside {simd_op_pkg::op_ukadd, simd_op_pkg::op_uksub}) begin
      if (r > m) begin
        r = m;
        ovf = 1'b1;
      end else if (r < 0) begin
        r = 0;
        ovf = 1'b1;
      end
    end
    // Halving floors toward minus infinity
    if (op inside {simd_op_pkg::op_radd, simd_op_pkg::op_rsub,
                   simd_op_pkg::op_uradd, simd_op_pkg::op_ursub}) r = r >>> 1;
    res = res | ((r & m) << (l * lw));
  end
  return {ovf, res[31:0]};
endfunction

`endif

//--- tb_simd_alu.sv
//////////////////////////////////////////////////
// Testbench for the packed-SIMD ALU
// Random and directed operands over every op and
// lane width with each result checked after its strobe
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_simd_alu;

  logic                       clk;
  logic                       arst_n;
  logic                       valid;
  simd_op_pkg::simd_op_e      op_sel;
  simd_lane_pkg::lane_width_e width_sel;
  simd_lane_pkg::data_t       op_a;
  simd_lane_pkg::data_t       op_b;
  simd_lane_pkg::data_t       result;
  logic                       ovf;
  logic                       valid_out;

  int          errors;
  int          checks;
  logic [31:0] rng_state;
  logic        exp_valid_q;
  logic [31:0] last_result;
  logic [31:0] exp_result_q[$];
  logic        exp_ovf_q[$];
  string       exp_name_q[$];

  `include "tb_simd_model.svh"

  simd_alu_top u_dut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .valid_i  (valid),
    .op_i     (op_sel),
    .width_i  (width_sel),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .result_o (result),
    .ovf_o    (ovf),
    .valid_o  (valid_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
    errors++;
    $display("ERROR %s %s: expected %08h actual %08h", name, field, expected, actual);
  endtask

  // Drive one operation and queue its expected result
  task automatic issue_op(input simd_op_pkg::simd_op_e op, input simd_lane_pkg::lane_width_e w,
                          input logic [31:0] a, input logic [31:0] b);
    logic [32:0] exp;
    exp = model_alu(op, w, a, b);
    valid = 1'b1;
    op_sel = op;
    width_sel = w;
    op_a = a;
    op_b = b;
    exp_result_q.push_back(exp[31:0]);
    exp_ovf_q.push_back(exp[32]);
    exp_name_q.push_back($sformatf("%s/%s a=%08h b=%08h", op.name(), w.name(), a, b));
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycle();
    valid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // Each op in the range over every width with directed and random operands
  task automatic run_group(input simd_op_pkg::simd_op_e first,
                           input simd_op_pkg::simd_op_e last);
    logic [31:0] dir_a [8];
    logic [31:0] dir_b [8];
    logic [31:0] r1;
    logic [31:0] r2;
    simd_lane_pkg::lane_width_e w;
    simd_op_pkg::simd_op_e op;
    dir_a = '{32'h7f7f7fff, 32'h80808000, 32'hffffffff, 32'h00000000,
              32'h12345678, 32'hffff0080, 32'h80000000, 32'h00ff7f01};
    dir_b = '{32'h01010101, 32'h01010101, 32'h01010101, 32'h01010101,
              32'h12345678, 32'hffff0001, 32'h7fffffff, 32'h80017f02};
    for (int k = int'(first); k <= int'(last); k++) begin
      op = simd_op_pkg::simd_op_e'(k);
      for (int wi = 0; wi < 3; wi++) begin
        w = simd_lane_pkg::lane_width_e'(wi);
        for (int d = 0; d < 8; d++) issue_op(op, w, dir_a[d], dir_b[d]);
        rng_state = lcg_next(rng_state);
        r1 = rng_state;
        rng_state = lcg_next(rng_state);
        r2 = rng_state;
        issue_op(op, w, r1, r2);
        issue_op(op, w, r1 >> r2[4:0], r2);
        issue_op(op, w, r1, r1 ^ (r2 & 32'hff00ff00));
        issue_op(op, w, ~r1 >> 3, r2);
      end
    end
  endtask

  task automatic drain_results();
    int waited;
    valid = 1'b0;
    waited = 0;
    while (exp_result_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (exp_result_q.size() != 0) begin
      errors++;
      $display("Timed out waiting for %0d outstanding results", exp_result_q.size());
    end
  endtask

  //////////////////////////////////////////////////
  // Output checker
  //////////////////////////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) exp_valid_q <= 1'b0;
    else exp_valid_q <= valid;
  end

  always @(negedge clk) begin
    string       name;
    logic [31:0] exp_res;
    logic        exp_ovf;
    if (arst_n) begin
      checks++;
      assert (valid_out === exp_valid_q) else
        report_mismatch("valid_follow", "valid_o", {31'b0, exp_valid_q}, {31'b0, valid_out});
      if (valid_out) begin
        if (exp_result_q.size() == 0) begin
          errors++;
          $display("A result appeared with no operation outstanding");
        end else begin
          name = exp_name_q.pop_front();
          exp_res = exp_result_q.pop_front();
          exp_ovf = exp_ovf_q.pop_front();
          assert (result === exp_res) else report_mismatch(name, "result_o", exp_res, result);
          assert (ovf === exp_ovf) else
            report_mismatch(name, "ovf_o", {31'b0, exp_ovf}, {31'b0, ovf});
          last_result = exp_res;
        end
      end else begin
        // Idle cycles keep the last result
        assert (result === last_result) else
          report_mismatch("idle_hold", "result_o", last_result, result);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    errors = 0;
    checks = 0;
    rng_state = 32'h8c858b22;
    last_result = '0;
    arst_n = 1'b0;
    valid = 1'b0;
    op_sel = simd_op_pkg::op_add;
    width_sel = simd_lane_pkg::w8;
    op_a = '0;
    op_b = '0;

    repeat (8) @(posedge clk);
    #1;
    checks++;
    assert (valid_out === 1'b0) else
      report_mismatch("reset", "valid_o", 32'h0, {31'b0, valid_out});
    assert (ovf === 1'b0) else
      report_mismatch("reset", "ovf_o", 32'h0, {31'b0, ovf});
    assert (result === '0) else
      report_mismatch("reset", "result_o", 32'h0, result);
    arst_n = 1'b1;
    idle_cycle();

    run_group(simd_op_pkg::op_add, simd_op_pkg::op_sub);
    run_group(simd_op_pkg::op_kadd, simd_op_pkg::op_uksub);
    run_group(simd_op_pkg::op_radd, simd_op_pkg::op_ursub);
    run_group(simd_op_pkg::op_cmpeq, simd_op_pkg::op_ucmple);
    run_group(simd_op_pkg::op_smin, simd_op_pkg::op_umax);
    run_group(simd_op_pkg::op_clz, simd_op_pkg::op_clrs);

    // Gaps between strobes where valid_o drops and the result holds
    repeat (3) idle_cycle();
    issue_op(simd_op_pkg::op_kadd, simd_lane_pkg::w16, 32'h7fff8000, 32'h0001ffff);
    repeat (2) idle_cycle();
    issue_op(simd_op_pkg::op_clrs, simd_lane_pkg::w32, 32'hfff00000, 32'h0);
    drain_results();
    idle_cycle();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
